// File: rtl/vlane_seq_consts.svh
`ifndef VLANE_SEQ_CONSTS_SVH
`define VLANE_SEQ_CONSTS_SVH

////////////////////////////////////////
// Lane geometry
////////////////////////////////////////
`define VLS_LANES           8
`define VLS_MEM_DEPTH       512        // Words per lane
`define VLS_MAX_VL_PER_LANE 256        // Elements per lane

////////////////////////////////////////
// Derived widths
////////////////////////////////////////
`define VLS_ADDR_W  ($clog2(`VLS_MEM_DEPTH))
`define VLS_VL_W    ($clog2(`VLS_LANES * `VLS_MAX_VL_PER_LANE))
`define VLS_CNT_W   ($clog2(`VLS_MAX_VL_PER_LANE) + 1)   // Holds read_limit and delay + limit
`define VLS_DELAY_W ($clog2(`VLS_MAX_VL_PER_LANE))
`define VLS_SEL_W   3                                    // Read port select

`endif

// File: rtl/vlane_cmd_pkg.sv
`include "vlane_seq_consts.svh"

package vlane_cmd_pkg;

    // Instruction kinds as issued by the dispatcher, gaps are unused kinds
    typedef enum logic [2:0] {
        INST_NORMAL    = 3'd0,
        INST_STORE     = 3'd2,
        INST_IDX_STORE = 3'd3,
        INST_LOAD      = 3'd4,
        INST_IDX_LOAD  = 3'd5
    } inst_type_e;

    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'd1,
        WIDTH_HALF = 2'd2,
        WIDTH_WORD = 2'd3
    } width_e;

    typedef struct packed {
        logic [1:0]            op2_sel;
        logic [`VLS_SEL_W-1:0] op3_sel;        // From port allocation
        logic [31:0]           x_data;         // Scalar operand
        logic [4:0]            imm;
        logic [5:0]            opmode;
        logic                  en_32bit_mul;
    } alu_ctrl_t;

    // Everything captured on acceptance
    typedef struct packed {
        inst_type_e                   inst_type;
        logic [`VLS_DELAY_W-1:0]      delay;      // Read to write latency in cycles
        logic [`VLS_VL_W-1:0]         vl;
        width_e                       rd_width;
        width_e                       wr_width;
        logic [2:0][`VLS_ADDR_W-1:0]  raddr;      // vs1, vs2, vs3
        logic [`VLS_ADDR_W-1:0]       waddr;
        logic                         mask;
        logic [`VLS_SEL_W-1:0]        store_data_sel;
        logic [`VLS_SEL_W-1:0]        index_sel;
        alu_ctrl_t                    alu;
    } vls_cmd_t;

endpackage

// File: rtl/vlane_vrf_pkg.sv
`include "vlane_seq_consts.svh"

package vlane_vrf_pkg;

    typedef logic [`VLS_ADDR_W-1:0]     vrf_addr_t;
    typedef logic [`VLS_LANES-1:0][3:0] lane_bwen_t;      // Four bytes per lane word
    typedef logic [`VLS_LANES-1:0]      lane_valid_t;

    // Source operand read side
    typedef struct packed {
        vrf_addr_t [2:0]       raddr;
        vlane_cmd_pkg::width_e width;
    } vrf_rd_t;

    // Destination write side, one address per lane
    typedef struct packed {
        vrf_addr_t [`VLS_LANES-1:0] waddr;
        lane_bwen_t                 bwen;
        vlane_cmd_pkg::width_e      width;
    } vrf_wr_t;

    typedef struct packed {
        logic                  store_data_valid;
        logic                  index_valid;
        logic                  ready_for_load;
        logic [`VLS_SEL_W-1:0] store_data_sel;
        logic [`VLS_SEL_W-1:0] index_sel;
        logic [1:0]            write_data_sel;    // 1 selects load data
    } lsu_ctrl_t;

    typedef struct packed {
        logic                  wen;
        logic [`VLS_CNT_W-2:0] addr;
    } vmrf_t;

endpackage

// File: rtl/vlane_seq_ctrl.sv
`timescale 1ns/1ns
`include "vlane_seq_consts.svh"

module vlane_seq_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  vlane_cmd_pkg::vls_cmd_t   cmd_i,
    input  logic                      load_last_i,
    output logic                      ready_o,
    output vlane_cmd_pkg::vls_cmd_t   cmd_o,
    output logic                      wr_en_o,
    output logic                      load_mode_o,
    output vlane_cmd_pkg::width_e     waddr_width_o,
    output logic                      waddr_load_o,
    output logic                      waddr_en_o,
    output logic                      raddr_load_o,
    output logic                      raddr_en_o,
    output logic                      rvalid_load_o,
    output logic                      rvalid_shift_o,
    output vlane_vrf_pkg::lsu_ctrl_t  lsu_o,
    output vlane_vrf_pkg::vmrf_t      vmrf_o
);
    import vlane_cmd_pkg::*;

    localparam int LANE_SHIFT = $clog2(`VLS_LANES);

    typedef enum logic [1:0] {ST_IDLE, ST_NORMAL, ST_READ, ST_LOAD} state_e;
    typedef logic [`VLS_CNT_W:0] span_t;   // One bit wider than the counter

    state_e                 state_q;
    state_e                 state_d;
    vls_cmd_t               cmd_q;
    logic                   start_q;
    logic [`VLS_CNT_W-1:0]  main_cnt_q;
    logic [`VLS_CNT_W-2:0]  mask_cnt_q;
    logic [`VLS_CNT_W-1:0]  read_limit;
    span_t                  cnt_ext;
    span_t                  write_end;
    logic                   rd_active;
    logic                   wr_active;
    logic                   normal_done;
    logic                   read_done;
    logic                   load_mode;
    logic                   is_store;
    logic                   is_index;

    ////////////////////////////////////////
    // Phase boundaries
    ////////////////////////////////////////
    // Words per lane, rounded up
    assign read_limit = `VLS_CNT_W'(cmd_q.vl >> LANE_SHIFT)
                      + `VLS_CNT_W'(|cmd_q.vl[LANE_SHIFT-1:0]);
    assign cnt_ext   = span_t'(main_cnt_q);
    assign write_end = span_t'(cmd_q.delay) + span_t'(read_limit);

    assign rd_active = (state_q == ST_NORMAL || state_q == ST_READ) &&
                       (main_cnt_q < read_limit);
    assign wr_active = (state_q == ST_NORMAL) && (cnt_ext >= span_t'(cmd_q.delay)) &&
                       (cnt_ext < write_end);
    assign normal_done = (cnt_ext + 1'b1) >= write_end;      // Last write cycle
    assign read_done   = (cnt_ext + 1'b1) >= span_t'(read_limit);
    assign load_mode   = (state_q == ST_LOAD);

    assign is_store = (cmd_q.inst_type == INST_STORE) || (cmd_q.inst_type == INST_IDX_STORE);
    assign is_index = (cmd_q.inst_type == INST_IDX_STORE) || (cmd_q.inst_type == INST_IDX_LOAD);

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_q) begin                 // Command registered last cycle
                    case (cmd_q.inst_type)
                        INST_NORMAL:    state_d = ST_NORMAL;
                        INST_STORE,
                        INST_IDX_STORE,
                        INST_IDX_LOAD:  state_d = ST_READ;
                        INST_LOAD:      state_d = ST_LOAD;
                        default:        state_d = ST_IDLE;
                    endcase
                end
            end
            ST_NORMAL: if (normal_done) state_d = ST_IDLE;
            ST_READ:   if (read_done) state_d = ST_IDLE;
            ST_LOAD:   if (load_last_i) state_d = ST_IDLE;   // Latency set by memory side
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= ST_IDLE;
            start_q    <= 1'b0;
            ready_o    <= 1'b1;
            main_cnt_q <= '0;
            mask_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            start_q <= start_i && ready_o;

            if (start_i && ready_o) begin
                ready_o <= 1'b0;
            end else if (!ready_o && state_d == ST_IDLE) begin
                ready_o <= 1'b1;
            end

            if (state_q == ST_IDLE) begin
                main_cnt_q <= '0;
            end else if (state_q != ST_LOAD) begin
                main_cnt_q <= main_cnt_q + 1'b1;
            end

            // Counts mask bits written so far
            if (state_q == ST_IDLE) begin
                mask_cnt_q <= '0;
            end else if (wr_active) begin
                mask_cnt_q <= mask_cnt_q + 1'b1;
            end
        end
    end

    // Command register
    always_ff @(posedge clk_i) begin
        if (start_i && ready_o) begin
            cmd_q <= cmd_i;
        end
    end

    ////////////////////////////////////////
    // Strobes to datapath
    ////////////////////////////////////////
    assign cmd_o          = cmd_q;
    assign wr_en_o        = wr_active;
    assign load_mode_o    = load_mode;
    assign waddr_width_o  = load_mode ? WIDTH_WORD : cmd_q.wr_width;   // Loads write full words
    assign waddr_load_o   = (state_q == ST_IDLE);
    assign waddr_en_o     = wr_active || load_mode;
    assign raddr_load_o   = (state_q == ST_IDLE);
    assign raddr_en_o     = rd_active;
    assign rvalid_load_o  = (state_q == ST_IDLE);
    assign rvalid_shift_o = rd_active;

    always_comb begin
        lsu_o.store_data_valid = rd_active && is_store;
        lsu_o.index_valid      = rd_active && is_index;
        lsu_o.ready_for_load   = load_mode;
        lsu_o.store_data_sel   = cmd_q.store_data_sel;
        lsu_o.index_sel        = cmd_q.index_sel;
        lsu_o.write_data_sel   = load_mode ? 2'b01 : 2'b00;
        vmrf_o.wen             = wr_active && cmd_q.mask;
        vmrf_o.addr            = mask_cnt_q;
    end

    // Write window must start after the first read
    a_normal_delay: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q == ST_NORMAL) |-> (cmd_q.delay != '0));

    a_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q != ST_IDLE) |-> !ready_o);

endmodule

// File: rtl/vrf_addr_counter.sv
`timescale 1ns/1ns
`include "vlane_seq_consts.svh"

module vrf_addr_counter (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     load_i,
    input  logic                     en_i,
    input  vlane_vrf_pkg::vrf_addr_t start_addr_i,
    input  vlane_cmd_pkg::width_e    width_i,
    output vlane_vrf_pkg::vrf_addr_t addr_o
);
    import vlane_cmd_pkg::*;

    logic [`VLS_ADDR_W-1:0] addr_q;
    logic [1:0]             phase_q;       // Element within current word
    logic [1:0]             phase_last;

    // Elements per word minus one
    always_comb begin
        case (width_i)
            WIDTH_BYTE: phase_last = 2'd3;
            WIDTH_HALF: phase_last = 2'd1;
            default:    phase_last = 2'd0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q  <= '0;
            phase_q <= '0;
        end else if (load_i) begin
            addr_q  <= start_addr_i;
            phase_q <= '0;
        end else if (en_i) begin
            if (phase_q == phase_last) begin   // Word full, move on
                phase_q <= '0;
                addr_q  <= addr_q + 1'b1;
            end else begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

    assign addr_o = addr_q;

endmodule

// File: rtl/bwen_gen.sv
`timescale 1ns/1ns
`include "vlane_seq_consts.svh"

module bwen_gen (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      wr_en_i,
    input  logic                      load_mode_i,
    input  vlane_cmd_pkg::width_e     width_i,
    input  vlane_vrf_pkg::lane_bwen_t load_bwen_i,
    output vlane_vrf_pkg::lane_bwen_t bwen_o
);
    import vlane_cmd_pkg::*;

    logic [3:0] shift4_q;    // Byte lane pointer
    logic [1:0] shift2_q;    // Half-word pointer
    logic [3:0] pattern;

    ////////////////////////////////////////
    // Rotating patterns
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            shift4_q <= 4'b0001;
            shift2_q <= 2'b01;
        end else if (wr_en_i) begin
            shift4_q <= {shift4_q[2:0], shift4_q[3]};
            shift2_q <= {shift2_q[0], shift2_q[1]};
        end else begin
            // Restart from the low byte for the next window
            shift4_q <= 4'b0001;
            shift2_q <= 2'b01;
        end
    end

    always_comb begin
        case (width_i)
            WIDTH_BYTE: pattern = shift4_q;
            WIDTH_HALF: pattern = {{2{shift2_q[1]}}, {2{shift2_q[0]}}};
            WIDTH_WORD: pattern = 4'b1111;
            default:    pattern = 4'b0000;
        endcase
    end

    // Loads take their enables from the memory side
    always_comb begin
        for (int i = 0; i < `VLS_LANES; i++) begin
            if (load_mode_i) begin
                bwen_o[i] = load_bwen_i[i];
            end else begin
                bwen_o[i] = wr_en_i ? pattern : 4'b0000;
            end
        end
    end

    // A byte write drives exactly one enable per lane
    a_byte_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
        (wr_en_i && width_i == WIDTH_BYTE) |-> $onehot(bwen_o[0]));

endmodule

// File: rtl/read_valid_gen.sv
`timescale 1ns/1ns
`include "vlane_seq_consts.svh"

module read_valid_gen (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       load_i,
    input  logic [`VLS_VL_W-1:0]       vl_i,
    input  logic                       shift_i,
    output vlane_vrf_pkg::lane_valid_t valid_o
);

    localparam int LANES = `VLS_LANES;

    logic [`VLS_VL_W-1:0] remain_q;    // Elements not yet read

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
        end else if (load_i) begin
            remain_q <= vl_i;
        end else if (shift_i) begin
            if (remain_q > LANES) begin
                remain_q <= remain_q - `VLS_VL_W'(LANES);   // One element per lane consumed
            end else begin
                remain_q <= '0;
            end
        end
    end

    // Lane i holds element c*LANES+i in read cycle c
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            valid_o[i] = shift_i && (remain_q > i);
        end
    end

endmodule

// File: rtl/vlane_seq.sv
`timescale 1ns/1ns
`include "vlane_seq_consts.svh"

module vlane_seq (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  vlane_cmd_pkg::vls_cmd_t    cmd_i,
    output logic                       ready_o,
    output vlane_vrf_pkg::vrf_rd_t     vrf_rd_o,
    output vlane_vrf_pkg::vrf_wr_t     vrf_wr_o,
    output vlane_vrf_pkg::lane_valid_t read_valid_o,
    output vlane_vrf_pkg::vmrf_t       vmrf_o,
    output vlane_vrf_pkg::lsu_ctrl_t   lsu_o,
    output vlane_cmd_pkg::alu_ctrl_t   alu_o,
    input  logic                       load_last_i,
    input  vlane_vrf_pkg::lane_bwen_t  load_bwen_i
);
    import vlane_cmd_pkg::*;
    import vlane_vrf_pkg::*;

    vls_cmd_t        cmd_q;
    width_e          waddr_width;
    logic            wr_en;
    logic            load_mode;
    logic            waddr_load;
    logic            waddr_en;
    logic            raddr_load;
    logic            raddr_en;
    logic            rvalid_load;
    logic            rvalid_shift;
    vrf_addr_t       waddr;
    vrf_addr_t [2:0] raddr;
    lane_bwen_t      bwen;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    vlane_seq_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .cmd_i          (cmd_i),
        .load_last_i    (load_last_i),
        .ready_o        (ready_o),
        .cmd_o          (cmd_q),
        .wr_en_o        (wr_en),
        .load_mode_o    (load_mode),
        .waddr_width_o  (waddr_width),
        .waddr_load_o   (waddr_load),
        .waddr_en_o     (waddr_en),
        .raddr_load_o   (raddr_load),
        .raddr_en_o     (raddr_en),
        .rvalid_load_o  (rvalid_load),
        .rvalid_shift_o (rvalid_shift),
        .lsu_o          (lsu_o),
        .vmrf_o         (vmrf_o)
    );

    ////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////
    vrf_addr_counter u_waddr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (waddr_load),
        .en_i         (waddr_en),
        .start_addr_i (cmd_q.waddr),
        .width_i      (waddr_width),
        .addr_o       (waddr)
    );

    for (genvar i = 0; i < 3; i++) begin : g_raddr   // vs1, vs2, vs3
        vrf_addr_counter u_raddr_cnt (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .load_i       (raddr_load),
            .en_i         (raddr_en),
            .start_addr_i (cmd_q.raddr[i]),
            .width_i      (cmd_q.rd_width),
            .addr_o       (raddr[i])
        );
    end

    bwen_gen u_bwen (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_en_i     (wr_en),
        .load_mode_i (load_mode),
        .width_i     (waddr_width),
        .load_bwen_i (load_bwen_i),
        .bwen_o      (bwen)
    );

    read_valid_gen u_rvalid (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .load_i  (rvalid_load),
        .vl_i    (cmd_q.vl),
        .shift_i (rvalid_shift),
        .valid_o (read_valid_o)
    );

    // All lanes share one write address
    always_comb begin
        vrf_rd_o.raddr = raddr;
        vrf_rd_o.width = cmd_q.rd_width;
        vrf_wr_o.waddr = {`VLS_LANES{waddr}};
        vrf_wr_o.bwen  = bwen;
        vrf_wr_o.width = waddr_width;
    end

    assign alu_o = cmd_q.alu;    // Held until next acceptance

endmodule

// File: sim/vlane_seq_tb.sv
`timescale 1ns/1ns
`include "vlane_seq_consts.svh"

module vlane_seq_tb;
    import vlane_cmd_pkg::*;
    import vlane_vrf_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_CMDS       = 40;
    localparam int MAX_CMD_CYCLES = 32;    // Gap, setup, delay, reads and load tail
    localparam int TIMEOUT_NS     = (RESET_CYCLES + NUM_CMDS * MAX_CMD_CYCLES) * CLK_PERIOD;
    localparam int LANES          = `VLS_LANES;

    logic        clk_i;
    logic        rst_i;
    logic        start_i;
    vls_cmd_t    cmd_i;
    logic        ready_o;
    vrf_rd_t     vrf_rd_o;
    vrf_wr_t     vrf_wr_o;
    lane_valid_t read_valid_o;
    vmrf_t       vmrf_o;
    lsu_ctrl_t   lsu_o;
    alu_ctrl_t   alu_o;
    logic        load_last_i;
    lane_bwen_t  load_bwen_i;

    logic [31:0] lfsr_state;
    int          error_count;
    int          checked_cycles;
    int          accepted_count;

    // Checker view of the instruction in flight
    vls_cmd_t    cur_cmd;
    logic        have_cmd;
    int          cyc;          // Cycles since acceptance
    int          load_k;       // Load cycles seen so far
    logic        load_on;

    vlane_seq vlane_seq_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start_i),
        .cmd_i        (cmd_i),
        .ready_o      (ready_o),
        .vrf_rd_o     (vrf_rd_o),
        .vrf_wr_o     (vrf_wr_o),
        .read_valid_o (read_valid_o),
        .vmrf_o       (vmrf_o),
        .lsu_o        (lsu_o),
        .alu_o        (alu_o),
        .load_last_i  (load_last_i),
        .load_bwen_i  (load_bwen_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};      // One step per bit
        end
        return v;
    endfunction

    function automatic width_e random_width();
        case (draw_bits(2) % 3)
            0:       return WIDTH_BYTE;
            1:       return WIDTH_HALF;
            default: return WIDTH_WORD;
        endcase
    endfunction

    function automatic vls_cmd_t make_command();
        vls_cmd_t c;
        c = '0;
        case (draw_bits(3) % 5)
            0:       c.inst_type = INST_NORMAL;
            1:       c.inst_type = INST_STORE;
            2:       c.inst_type = INST_IDX_STORE;
            3:       c.inst_type = INST_LOAD;
            default: c.inst_type = INST_IDX_LOAD;
        endcase
        c.delay    = `VLS_DELAY_W'(1 + draw_bits(3));     // Never zero
        c.vl       = `VLS_VL_W'(1 + draw_bits(6));
        c.rd_width = random_width();
        c.wr_width = random_width();
        for (int j = 0; j < 3; j++) begin
            c.raddr[j] = vrf_addr_t'(draw_bits(`VLS_ADDR_W));
        end
        c.waddr            = vrf_addr_t'(draw_bits(`VLS_ADDR_W));
        c.mask             = 1'(draw_bits(1));
        c.store_data_sel   = `VLS_SEL_W'(draw_bits(3));
        c.index_sel        = `VLS_SEL_W'(draw_bits(3));
        c.alu.op2_sel      = 2'(draw_bits(2));
        c.alu.op3_sel      = `VLS_SEL_W'(draw_bits(3));
        c.alu.x_data       = draw_bits(32);
        c.alu.imm          = 5'(draw_bits(5));
        c.alu.opmode       = 6'(draw_bits(6));
        c.alu.en_32bit_mul = 1'(draw_bits(1));
        return c;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic int read_limit(input int vl);
        return (vl + LANES - 1) / LANES;
    endfunction

    // Word address after idx elements of the given width
    function automatic vrf_addr_t exp_addr(input vrf_addr_t start, input int idx, input width_e w);
        int epw;
        case (w)
            WIDTH_BYTE: epw = 4;
            WIDTH_HALF: epw = 2;
            default:    epw = 1;
        endcase
        return vrf_addr_t'(int'(start) + idx / epw);
    endfunction

    function automatic logic [3:0] exp_pattern(input width_e w, input int k);
        case (w)
            WIDTH_BYTE: return 4'b0001 << (k % 4);
            WIDTH_HALF: return (k % 2 == 0) ? 4'b0011 : 4'b1100;
            default:    return 4'b1111;
        endcase
    endfunction

    function automatic lane_valid_t lane_valid_mask(input int vl, input int c);
        lane_valid_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = (c * LANES + i) < vl;
        end
        return v;
    endfunction

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns: %s", $time, what);
        error_count = error_count + 1;
    endtask

    ////////////////////////////////////////
    // Output comparison
    ////////////////////////////////////////
    always @(negedge clk_i) begin : check_outputs
        int                    p;
        int                    rl;
        int                    k;
        logic                  in_mode;
        logic                  rd;
        logic                  wr;
        logic                  lm;
        logic                  is_store;
        logic                  is_index;
        lane_valid_t           exp_valid;
        lane_bwen_t            exp_bwen;
        vrf_addr_t             exp_waddr;
        logic [`VLS_CNT_W-2:0] exp_maddr;
        if (rst_i) begin
            checked_cycles = checked_cycles + 1;
            if (have_cmd)
                cyc = cyc + 1;
            p  = cyc - 2;                          // Mode cycle, 0 at T+2
            rl = have_cmd ? read_limit(int'(cur_cmd.vl)) : 0;
            k  = have_cmd ? p - int'(cur_cmd.delay) : 0;
            if (!have_cmd || cyc < 2)
                in_mode = 1'b0;
            else if (cur_cmd.inst_type == INST_LOAD)
                in_mode = load_on;
            else if (cur_cmd.inst_type == INST_NORMAL)
                in_mode = p < int'(cur_cmd.delay) + rl;
            else
                in_mode = p < rl;
            lm = in_mode && cur_cmd.inst_type == INST_LOAD;
            rd = in_mode && !lm && p < rl;
            wr = in_mode && cur_cmd.inst_type == INST_NORMAL && k >= 0;
            is_store = have_cmd && (cur_cmd.inst_type inside {INST_STORE, INST_IDX_STORE});
            is_index = have_cmd && (cur_cmd.inst_type inside {INST_IDX_STORE, INST_IDX_LOAD});
            exp_valid = rd ? lane_valid_mask(int'(cur_cmd.vl), p) : '0;
            if (lm)
                exp_bwen = load_bwen_i;
            else if (wr)
                exp_bwen = {LANES{exp_pattern(cur_cmd.wr_width, k)}};
            else
                exp_bwen = '0;

            if (ready_o !== !(have_cmd && (cyc == 1 || in_mode)))
                report_mismatch($sformatf("ready_o %b, cycle %0d", ready_o, cyc));
            if (read_valid_o !== exp_valid)
                report_mismatch($sformatf("read_valid %b, expected %b", read_valid_o, exp_valid));
            if (vrf_wr_o.bwen !== exp_bwen)
                report_mismatch($sformatf("bwen %h, expected %h", vrf_wr_o.bwen, exp_bwen));
            if (lsu_o.store_data_valid !== (rd && is_store) || lsu_o.index_valid !== (rd && is_index))
                report_mismatch($sformatf("store/index valid %b%b", lsu_o.store_data_valid,
                                          lsu_o.index_valid));
            if (lsu_o.ready_for_load !== lm || lsu_o.write_data_sel !== (lm ? 2'b01 : 2'b00))
                report_mismatch($sformatf("ready_for_load %b", lsu_o.ready_for_load));
            if (vmrf_o.wen !== (wr && cur_cmd.mask))
                report_mismatch($sformatf("vmrf wen %b", vmrf_o.wen));
            exp_maddr = k[`VLS_CNT_W-2:0];
            if (wr && vmrf_o.addr !== exp_maddr)
                report_mismatch($sformatf("vmrf addr %0d, expected %0d", vmrf_o.addr, exp_maddr));
            if (rd) begin
                for (int j = 0; j < 3; j++) begin
                    if (vrf_rd_o.raddr[j] !== exp_addr(cur_cmd.raddr[j], p, cur_cmd.rd_width))
                        report_mismatch($sformatf("raddr[%0d] %0d at read %0d", j,
                                                  vrf_rd_o.raddr[j], p));
                end
            end
            if (wr || lm) begin
                exp_waddr = lm ? vrf_addr_t'(int'(cur_cmd.waddr) + load_k)
                               : exp_addr(cur_cmd.waddr, k, cur_cmd.wr_width);
                for (int i = 0; i < LANES; i++) begin
                    if (vrf_wr_o.waddr[i] !== exp_waddr)
                        report_mismatch($sformatf("waddr lane %0d is %0d, expected %0d", i,
                                                  vrf_wr_o.waddr[i], exp_waddr));
                end
            end
            if (have_cmd) begin
                if (alu_o !== cur_cmd.alu)
                    report_mismatch("alu controls differ from captured command");
                if (vrf_rd_o.width !== cur_cmd.rd_width)
                    report_mismatch($sformatf("read width %0d", vrf_rd_o.width));
                if (vrf_wr_o.width !== (lm ? WIDTH_WORD : cur_cmd.wr_width))
                    report_mismatch($sformatf("write width %0d", vrf_wr_o.width));
                if (lsu_o.store_data_sel !== cur_cmd.store_data_sel ||
                    lsu_o.index_sel !== cur_cmd.index_sel)
                    report_mismatch("store selects differ from captured command");
            end

            if (lm) begin
                load_k = load_k + 1;
                if (load_last_i)
                    load_on = 1'b0;                // Idle next cycle
            end
            if (start_i && ready_o) begin          // Accepted at the coming edge
                cur_cmd        = cmd_i;
                have_cmd       = 1'b1;
                cyc            = 0;
                load_k         = 0;
                load_on        = 1'b1;
                accepted_count = accepted_count + 1;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic step_cycle();
        @(posedge clk_i);
        #1;
        load_bwen_i = lane_bwen_t'(draw_bits(LANES * 4));
    endtask

    task automatic issue_command(input vls_cmd_t cmd, input int load_len);
        while (!ready_o)
            step_cycle();
        start_i = 1'b1;
        cmd_i   = cmd;
        step_cycle();
        start_i = 1'b0;
        cmd_i   = make_command();                  // DUT keeps the captured one
        if (cmd.inst_type == INST_LOAD) begin
            repeat (load_len) step_cycle();
            load_last_i = 1'b1;
            step_cycle();
            load_last_i = 1'b0;
        end
    endtask

    initial begin : run_test
        vls_cmd_t next_cmd;
        int       load_len;
        clk_i          = 1'b0;
        rst_i          = 1'b0;
        start_i        = 1'b0;
        cmd_i          = '0;
        load_last_i    = 1'b0;
        load_bwen_i    = '0;
        lfsr_state     = 32'h0706_d473;
        error_count    = 0;
        checked_cycles = 0;
        accepted_count = 0;
        have_cmd       = 1'b0;
        cyc            = 0;
        load_k         = 0;
        load_on        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        for (int n = 0; n < NUM_CMDS; n++) begin
            repeat (draw_bits(2)) step_cycle();    // Idle gap, zero allowed
            next_cmd = make_command();
            load_len = 1 + int'(draw_bits(3));
            issue_command(next_cmd, load_len);
        end
        while (!ready_o)
            step_cycle();
        repeat (4) step_cycle();
        if (accepted_count != NUM_CMDS) begin
            $display("Only %0d of %0d commands were accepted", accepted_count, NUM_CMDS);
            error_count = error_count + 1;
        end
        $display("Commands: %0d, cycles checked: %0d, errors: %0d",
                 accepted_count, checked_cycles, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the command sequence did not complete", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: vlane_seq.f
+incdir+rtl
rtl/vlane_cmd_pkg.sv
rtl/vlane_vrf_pkg.sv
rtl/vlane_seq_ctrl.sv
rtl/vrf_addr_counter.sv
rtl/bwen_gen.sv
rtl/read_valid_gen.sv
rtl/vlane_seq.sv
sim/vlane_seq_tb.sv
